// ==== source/dcp_pkg.sv ====
// ------------------------------------------------
// shared types and constants for the dehaze display path
// import inside module bodies, scoped names in port lists
// ------------------------------------------------
package dcp_pkg;

    // ------------------------------------------------
    // data types
    typedef logic [7:0] chan_t;       // one colour channel
    typedef logic [9:0] in_chan_t;    // frame memory / display word

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } pix_t;

    // 4 integer bits, 16 fraction bits
    typedef logic [19:0] recip_t;

    // ------------------------------------------------
    // enums
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAITING,
        ST_PROCESSING
    } seq_state_t;

    typedef enum logic [2:0] {
        DISP_ORIGIN       = 3'd0,
        DISP_TRANSMISSION = 3'd1,
        DISP_DEHAZE       = 3'd2
    } display_mode_t;

    // ------------------------------------------------
    // reciprocal table
    localparam int T_FLOOR         = 26;   // keeps 1/t bounded
    localparam int RECIP_NUMERATOR = 255;

    // floor(255 * 2^16 / max(t, 26)), used to fill the per-channel lut
    function automatic recip_t recip_of(input chan_t t);
        int unsigned den;
        int unsigned num;
        den = (int'(t) < T_FLOOR) ? T_FLOOR : int'(t);
        num = RECIP_NUMERATOR << 16;
        return recip_t'(num / den);
    endfunction

endpackage

// ==== source/dcp_sequencer.sv ====
// ------------------------------------------------
// start-up wait, fill wait and prefetch control
// drives the frame memory read and the capture strobe
// ------------------------------------------------
module dcp_sequencer #(
    parameter int LINE_WIDTH     = 640,
    parameter int WAIT_CYCLES    = 33554431,
    parameter int PREFETCH_LINES = 5
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_vga_request,
    output logic o_sdram_read,
    output logic o_shift,
    output logic o_est_en
);
    import dcp_pkg::*;

    localparam int FILL_CYCLES  = 3 * LINE_WIDTH + 2;
    localparam int PREFETCH_NUM = PREFETCH_LINES * LINE_WIDTH;
    localparam int PF_W         = $clog2(PREFETCH_NUM + 1);

    seq_state_t      state;
    logic [31:0]     wait_cnt;
    logic [PF_W-1:0] prefetch_cnt;
    logic            in_proc;
    logic            prefetching;

    // ------------------------------------------------
    // strobes
    assign in_proc     = (state == ST_PROCESSING);
    assign prefetching = in_proc && (prefetch_cnt < PF_W'(PREFETCH_NUM));

    // pass-through before processing, forced high while prefetching
    assign o_sdram_read = prefetching | i_vga_request;
    assign o_est_en     = in_proc;

    // ------------------------------------------------
    // state machine
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wait_cnt == 32'(WAIT_CYCLES)) begin
                        state    <= ST_WAITING;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                ST_WAITING: begin
                    // let three rows worth of cycles go by
                    if (wait_cnt == 32'(FILL_CYCLES - 1)) begin
                        state    <= ST_PROCESSING;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                ST_PROCESSING: begin
                    state <= ST_PROCESSING;   // stays here for good
                end
                default: begin
                    state    <= ST_IDLE;
                    wait_cnt <= '0;
                end
            endcase
        end
    end

    // ------------------------------------------------
    // prefetch count and capture strobe
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            prefetch_cnt <= '0;
            o_shift      <= 1'b0;
        end else begin
            if (prefetching) begin
                prefetch_cnt <= prefetch_cnt + 1'b1;
            end
            // read data lands one cycle after the strobe
            o_shift <= in_proc & o_sdram_read;
        end
    end

endmodule

// ==== source/line_buffer.sv ====
// ------------------------------------------------
// three cascaded pixel rows feeding the estimator column
// plus a short tap delay giving the aligned pixel
// ------------------------------------------------
module line_buffer #(
    parameter int LINE_WIDTH = 640,
    parameter int TAP_DEPTH  = 3
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_shift,
    input  dcp_pkg::in_chan_t      i_red_data,
    input  dcp_pkg::in_chan_t      i_green_data,
    input  dcp_pkg::in_chan_t      i_blue_data,
    output dcp_pkg::pix_t    [2:0] o_column,
    output dcp_pkg::pix_t          o_aligned
);
    import dcp_pkg::*;

    pix_t pixel_in;
    pix_t rows [3][LINE_WIDTH];
    pix_t taps [TAP_DEPTH];

    // keep the top 8 bits of each channel
    assign pixel_in = {i_red_data[9:2], i_green_data[9:2], i_blue_data[9:2]};

    // ------------------------------------------------
    // shift on capture only, hold otherwise
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < 3; r++) begin
                for (int j = 0; j < LINE_WIDTH; j++) begin
                    rows[r][j] <= '0;
                end
            end
            for (int k = 0; k < TAP_DEPTH; k++) begin
                taps[k] <= '0;
            end
        end else if (i_shift) begin
            rows[0][0] <= pixel_in;
            for (int r = 1; r < 3; r++) begin
                rows[r][0] <= rows[r-1][LINE_WIDTH-1];   // row cascade
            end
            for (int r = 0; r < 3; r++) begin
                for (int j = 1; j < LINE_WIDTH; j++) begin
                    rows[r][j] <= rows[r][j-1];
                end
            end

            taps[0] <= rows[2][LINE_WIDTH-1];
            for (int k = 1; k < TAP_DEPTH; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    // ------------------------------------------------
    // outputs
    // row 1 sits in the top slot of the column
    assign o_column = {rows[0][LINE_WIDTH-1], rows[1][LINE_WIDTH-1], rows[2][LINE_WIDTH-1]};

    // matches estimator latency
    assign o_aligned = taps[TAP_DEPTH-1];

endmodule

// ==== source/dehaze_channel.sv ====
// ------------------------------------------------
// reciprocal, multiply, subtract recovery for one channel
// ------------------------------------------------
module dehaze_channel #(
    parameter int AIRLIGHT = 255
) (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_shift,
    input  dcp_pkg::chan_t i_pixel,
    input  dcp_pkg::chan_t i_trans,
    output dcp_pkg::chan_t o_pixel,
    output dcp_pkg::chan_t o_trans,
    output dcp_pkg::chan_t o_dehazed
);
    import dcp_pkg::*;

    localparam chan_t AIR = chan_t'(AIRLIGHT);

    recip_t      recip_lut [256];
    chan_t       s1_pixel, s1_trans;
    recip_t      s1_recip;
    chan_t       s2_pixel, s2_trans;
    logic [23:0] s2_prod;
    chan_t       s3_pixel, s3_trans, s3_dehazed;
    chan_t       diff;
    logic [8:0]  sub;

    // table filled at elaboration
    for (genvar t = 0; t < 256; t++) begin : g_lut
        assign recip_lut[t] = recip_of(chan_t'(t));
    end

    assign diff = (s1_pixel > AIR) ? '0 : AIR - s1_pixel;   // clamp at zero
    assign sub  = {1'b0, AIR} - {1'b0, s2_prod[23:16]};     // msb set if negative

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s1_pixel   <= '0;
            s1_trans   <= '0;
            s1_recip   <= '0;
            s2_pixel   <= '0;
            s2_trans   <= '0;
            s2_prod    <= '0;
            s3_pixel   <= '0;
            s3_trans   <= '0;
            s3_dehazed <= '0;
        end else if (i_shift) begin
            s1_pixel   <= i_pixel;
            s1_trans   <= i_trans;
            s1_recip   <= recip_lut[i_trans];
            s2_pixel   <= s1_pixel;
            s2_trans   <= s1_trans;
            s2_prod    <= {4'd0, s1_recip} * {16'd0, diff};
            s3_pixel   <= s2_pixel;
            s3_trans   <= s2_trans;
            s3_dehazed <= sub[8] ? '0 : sub[7:0];
        end
    end

    assign o_pixel   = s3_pixel;
    assign o_trans   = s3_trans;
    assign o_dehazed = s3_dehazed;

endmodule

// ==== source/dehaze_unit.sv ====
// ------------------------------------------------
// three channel pipelines and the display mode select
// ------------------------------------------------
module dehaze_unit #(
    parameter int AIR_RED   = 255,
    parameter int AIR_GREEN = 255,
    parameter int AIR_BLUE  = 255
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_shift,
    input  dcp_pkg::pix_t         i_aligned,
    input  dcp_pkg::chan_t        i_trans_r,
    input  dcp_pkg::chan_t        i_trans_g,
    input  dcp_pkg::chan_t        i_trans_b,
    input  dcp_pkg::display_mode_t i_display_option,
    output dcp_pkg::in_chan_t     o_red_out,
    output dcp_pkg::in_chan_t     o_green_out,
    output dcp_pkg::in_chan_t     o_blue_out
);
    import dcp_pkg::*;

    chan_t red_pix, red_t, red_dh;
    chan_t grn_pix, grn_t, grn_dh;
    chan_t blu_pix, blu_t, blu_dh;
    chan_t sel_r, sel_g, sel_b;

    // ------------------------------------------------
    // channel pipelines
    dehaze_channel #(.AIRLIGHT(AIR_RED)) red_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_shift(i_shift),
        .i_pixel(i_aligned.red), .i_trans(i_trans_r),
        .o_pixel(red_pix), .o_trans(red_t), .o_dehazed(red_dh)
    );

    dehaze_channel #(.AIRLIGHT(AIR_GREEN)) green_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_shift(i_shift),
        .i_pixel(i_aligned.green), .i_trans(i_trans_g),
        .o_pixel(grn_pix), .o_trans(grn_t), .o_dehazed(grn_dh)
    );

    dehaze_channel #(.AIRLIGHT(AIR_BLUE)) blue_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_shift(i_shift),
        .i_pixel(i_aligned.blue), .i_trans(i_trans_b),
        .o_pixel(blu_pix), .o_trans(blu_t), .o_dehazed(blu_dh)
    );

    // ------------------------------------------------
    // display select
    always_comb begin
        case (i_display_option)
            DISP_ORIGIN: begin
                sel_r = red_pix;
                sel_g = grn_pix;
                sel_b = blu_pix;
            end
            DISP_TRANSMISSION: begin   // transmission map
                sel_r = red_t;
                sel_g = grn_t;
                sel_b = blu_t;
            end
            DISP_DEHAZE: begin
                sel_r = red_dh;
                sel_g = grn_dh;
                sel_b = blu_dh;
            end
            default: begin             // unknown codes show the camera image
                sel_r = red_pix;
                sel_g = grn_pix;
                sel_b = blu_pix;
            end
        endcase
    end

    // back to 10-bit display words
    assign o_red_out   = {sel_r, 2'b00};
    assign o_green_out = {sel_g, 2'b00};
    assign o_blue_out  = {sel_b, 2'b00};

endmodule

// ==== source/dcp_top.sv ====
// ------------------------------------------------
// dehaze display path top, estimator sits outside
// exports the pixel column and takes transmission back
// ------------------------------------------------
module dcp_top #(
    parameter int LINE_WIDTH     = 640,
    parameter int TAP_DEPTH      = 3,
    parameter int WAIT_CYCLES    = 33554431,
    parameter int PREFETCH_LINES = 5,
    parameter int AIR_RED        = 255,
    parameter int AIR_GREEN      = 255,
    parameter int AIR_BLUE       = 255
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  dcp_pkg::in_chan_t      i_red_data,
    input  dcp_pkg::in_chan_t      i_green_data,
    input  dcp_pkg::in_chan_t      i_blue_data,
    input  logic                   i_vga_request,
    input  dcp_pkg::display_mode_t i_display_option,
    input  dcp_pkg::chan_t         i_trans_r,
    input  dcp_pkg::chan_t         i_trans_g,
    input  dcp_pkg::chan_t         i_trans_b,
    output logic                   o_sdram_read,
    output logic                   o_est_en,
    output dcp_pkg::pix_t    [2:0] o_column,
    output dcp_pkg::in_chan_t      o_red_out,
    output dcp_pkg::in_chan_t      o_green_out,
    output dcp_pkg::in_chan_t      o_blue_out
);
    import dcp_pkg::*;

    logic shift;     // capture strobe, freezes the path when low
    pix_t aligned;

    dcp_sequencer #(
        .LINE_WIDTH(LINE_WIDTH), .WAIT_CYCLES(WAIT_CYCLES),
        .PREFETCH_LINES(PREFETCH_LINES)
    ) seq_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_vga_request(i_vga_request),
        .o_sdram_read(o_sdram_read), .o_shift(shift), .o_est_en(o_est_en)
    );

    line_buffer #(
        .LINE_WIDTH(LINE_WIDTH), .TAP_DEPTH(TAP_DEPTH)
    ) lbuf_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_shift(shift),
        .i_red_data(i_red_data), .i_green_data(i_green_data),
        .i_blue_data(i_blue_data),
        .o_column(o_column), .o_aligned(aligned)
    );

    dehaze_unit #(
        .AIR_RED(AIR_RED), .AIR_GREEN(AIR_GREEN), .AIR_BLUE(AIR_BLUE)
    ) dehaze_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_shift(shift),
        .i_aligned(aligned),
        .i_trans_r(i_trans_r), .i_trans_g(i_trans_g), .i_trans_b(i_trans_b),
        .i_display_option(i_display_option),
        .o_red_out(o_red_out), .o_green_out(o_green_out), .o_blue_out(o_blue_out)
    );

endmodule

// ==== verif/dcp_assertions.sv ====
// ------------------------------------------------
// concurrent checks on the sequencer strobes
// ------------------------------------------------
module dcp_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_vga_request,
    input logic i_sdram_read,
    input logic i_shift,
    input logic i_est_en,
    input logic i_in_proc
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_read_follows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_in_proc |-> (i_sdram_read == i_vga_request))
        else begin
            fail_count++;
            $error("read strobe differs from request outside processing");
        end

    a_est_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_in_proc |-> !i_est_en)
        else begin
            fail_count++;
            $error("estimator enable high outside processing");
        end

    // capture strobe lags the processing read by one cycle
    a_shift_lag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (i_shift == $past(i_in_proc && i_sdram_read)))
        else begin
            fail_count++;
            $error("capture strobe does not match the previous read");
        end

    a_reset_quiet: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_est_en)
        else begin
            fail_count++;
            $error("estimator enable high right after reset");
        end

endmodule

// ==== verif/tb_dcp.sv ====
// ------------------------------------------------
// random stimulus testbench for the dehaze display path
// model mirrors the sequencer and records every capture
// ------------------------------------------------
module tb_dcp;
    timeunit 1ns;
    timeprecision 1ps;
    import dcp_pkg::*;

    localparam int LINE_WIDTH     = 8;
    localparam int TAP_DEPTH      = 3;
    localparam int WAIT_CYCLES    = 20;
    localparam int PREFETCH_LINES = 2;
    localparam int AIR_RED        = 255;
    localparam int AIR_GREEN      = 200;
    localparam int AIR_BLUE       = 230;

    localparam int FILL_CYCLES    = 3 * LINE_WIDTH + 2;
    localparam int PREFETCH_NUM   = PREFETCH_LINES * LINE_WIDTH;
    localparam int PIX_LAG        = 3 * LINE_WIDTH + TAP_DEPTH + 3;   // captures to stage 3
    localparam int TRANS_LAG      = 3;
    localparam int RESET_CYCLES   = 8;
    localparam int RUN_CYCLES     = 2000;
    localparam int HOLD_CYCLES    = 100;
    localparam int TIMEOUT_CYCLES = 3000;   // run takes about 2120 cycles

    logic          clk;
    logic          rst_n;
    in_chan_t      red_data, green_data, blue_data;
    logic          vga_request;
    display_mode_t mode;
    chan_t         trans_r, trans_g, trans_b;
    logic          sdram_read;
    logic          est_en;
    pix_t    [2:0] column;
    in_chan_t      red_out, green_out, blue_out;

    // model state
    int       m_phase;   // 0 idle, 1 fill wait, 2 processing
    int       m_wait;
    int       m_pf;
    logic     m_shift;
    int       m_caps;
    logic     exp_read;
    pix_t     pix_q[$];
    pix_t     trans_q[$];
    logic     freeze_req;
    logic     frozen;
    in_chan_t snap_r, snap_g, snap_b;
    pix_t     [2:0] snap_col;
    int       pf_cycles;   // first processing cycles seen on the DUT
    int       pf_reads;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    dcp_top #(
        .LINE_WIDTH(LINE_WIDTH), .TAP_DEPTH(TAP_DEPTH), .WAIT_CYCLES(WAIT_CYCLES),
        .PREFETCH_LINES(PREFETCH_LINES),
        .AIR_RED(AIR_RED), .AIR_GREEN(AIR_GREEN), .AIR_BLUE(AIR_BLUE)
    ) dcp_top_inst (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_red_data(red_data), .i_green_data(green_data), .i_blue_data(blue_data),
        .i_vga_request(vga_request), .i_display_option(mode),
        .i_trans_r(trans_r), .i_trans_g(trans_g), .i_trans_b(trans_b),
        .o_sdram_read(sdram_read), .o_est_en(est_en), .o_column(column),
        .o_red_out(red_out), .o_green_out(green_out), .o_blue_out(blue_out)
    );

    bind dcp_sequencer dcp_assertions chk_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_vga_request(i_vga_request),
        .i_sdram_read(o_sdram_read), .i_shift(o_shift), .i_est_en(o_est_en),
        .i_in_proc(in_proc)
    );

    // ------------------------------------------------
    // helpers
    task automatic check_equal(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic pix_t pixel_at(int idx);
        return (idx < 0) ? pix_t'(0) : pix_q[idx];   // zero fill before first pixel
    endfunction

    function automatic int dehazed_value(int caps, int air, int pix, int t);
        int den;
        int diff;
        int scaled;
        int res;
        if (caps == 0) begin
            return 0;                  // stage 3 still at reset
        end
        if (caps < 3) begin
            return air;                // product stage still zero
        end
        den    = (t < 26) ? 26 : t;
        diff   = (pix > air) ? 0 : air - pix;
        scaled = ((255 * 65536 / den) * diff) >> 16;
        res    = air - (scaled & 255);
        return (res < 0) ? 0 : res;
    endfunction

    function automatic display_mode_t mode_for(int step);
        case (step % 4)
            0: return DISP_ORIGIN;
            1: return DISP_DEHAZE;
            2: return DISP_TRANSMISSION;
            default: return display_mode_t'(3'd5);   // unlisted code, shows original
        endcase
    endfunction

    task automatic drive_random_inputs();
        red_data   <= in_chan_t'($urandom);
        green_data <= in_chan_t'($urandom);
        blue_data  <= in_chan_t'($urandom);
        // one draw in four lands near or below the floor
        trans_r <= ($urandom_range(0, 3) == 0) ? chan_t'($urandom_range(0, 30)) : chan_t'($urandom);
        trans_g <= ($urandom_range(0, 3) == 0) ? chan_t'($urandom_range(0, 30)) : chan_t'($urandom);
        trans_b <= ($urandom_range(0, 3) == 0) ? chan_t'($urandom_range(0, 30)) : chan_t'($urandom);
    endtask

    task automatic check_outputs();
        pix_t p;
        pix_t t;
        pix_t sel;
        p = pixel_at(m_caps - PIX_LAG);
        t = (m_caps >= TRANS_LAG) ? trans_q[m_caps - TRANS_LAG] : pix_t'(0);
        case (mode)
            DISP_TRANSMISSION: sel = t;
            DISP_DEHAZE: begin
                sel.red   = chan_t'(dehazed_value(m_caps, AIR_RED, p.red, t.red));
                sel.green = chan_t'(dehazed_value(m_caps, AIR_GREEN, p.green, t.green));
                sel.blue  = chan_t'(dehazed_value(m_caps, AIR_BLUE, p.blue, t.blue));
            end
            default: sel = p;
        endcase
        check_equal(int'(red_out), 4 * int'(sel.red), "red output");
        check_equal(int'(green_out), 4 * int'(sel.green), "green output");
        check_equal(int'(blue_out), 4 * int'(sel.blue), "blue output");
        check_equal(int'(column[2]), int'(pixel_at(m_caps - LINE_WIDTH)), "column row 1");
        check_equal(int'(column[1]), int'(pixel_at(m_caps - 2 * LINE_WIDTH)), "column row 2");
        check_equal(int'(column[0]), int'(pixel_at(m_caps - 3 * LINE_WIDTH)), "column row 3");
    endtask

    // ------------------------------------------------
    // model, checked on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            m_phase   = 0;
            m_wait    = 0;
            m_pf      = 0;
            m_shift   = 1'b0;
            m_caps    = 0;
            frozen    = 1'b0;
            pf_cycles = 0;
            pf_reads  = 0;
        end else begin
            exp_read = (m_phase == 2 && m_pf < PREFETCH_NUM) ? 1'b1 : vga_request;
            check_equal(int'(sdram_read), int'(exp_read), "read strobe");
            check_equal(int'(est_en), int'(m_phase == 2), "estimator enable");
            check_outputs();
            // reads seen in the first processing cycles
            if (est_en && pf_cycles < PREFETCH_NUM) begin
                pf_cycles++;
                if (sdram_read) begin
                    pf_reads++;
                end
            end
            if (frozen) begin
                check_equal(int'(red_out), int'(snap_r), "frozen red");
                check_equal(int'(green_out), int'(snap_g), "frozen green");
                check_equal(int'(blue_out), int'(snap_b), "frozen blue");
                for (int k = 0; k < 3; k++) begin
                    check_equal(int'(column[k]), int'(snap_col[k]), "frozen column");
                end
            end else if (freeze_req) begin
                snap_r   = red_out;
                snap_g   = green_out;
                snap_b   = blue_out;
                snap_col = column;
                frozen   = 1'b1;
            end
            // next rising edge captures what sits on the inputs now
            if (m_shift) begin
                pix_q.push_back({red_data[9:2], green_data[9:2], blue_data[9:2]});
                trans_q.push_back({trans_r, trans_g, trans_b});
                m_caps++;
            end
            m_shift = (m_phase == 2) && exp_read;
            if (m_phase == 2 && m_pf < PREFETCH_NUM) begin
                m_pf++;
            end
            if (m_phase == 0) begin
                m_wait  = (m_wait == WAIT_CYCLES) ? 0 : m_wait + 1;
                m_phase = (m_wait == 0) ? 1 : 0;
            end else if (m_phase == 1) begin
                m_wait  = (m_wait == FILL_CYCLES - 1) ? 0 : m_wait + 1;
                m_phase = (m_wait == 0) ? 2 : 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------
    // stimulus
    initial begin
        int hold_left;
        int step;
        int asserts;
        void'($urandom(32'hb012));
        rst_n       = 1'b0;
        red_data    = '0;
        green_data  = '0;
        blue_data   = '0;
        trans_r     = '0;
        trans_g     = '0;
        trans_b     = '0;
        vga_request = 1'b0;
        mode        = DISP_ORIGIN;
        freeze_req  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        step      = 0;
        hold_left = $urandom_range(150, 300);
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            drive_random_inputs();
            vga_request <= ($urandom_range(0, 99) < 60);
            hold_left--;
            if (hold_left == 0) begin
                step++;
                mode      <= mode_for(step);
                hold_left = $urandom_range(150, 300);
            end
        end

        // request stays low, path must freeze
        @(posedge clk);
        vga_request <= 1'b0;
        mode        <= DISP_TRANSMISSION;
        drive_random_inputs();
        repeat (3) begin
            @(posedge clk);
            drive_random_inputs();
        end
        freeze_req <= 1'b1;
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            drive_random_inputs();
        end
        @(posedge clk);

        check_equal(pf_reads, PREFETCH_NUM, "prefetch reads");
        if (m_caps <= PIX_LAG + 50) begin
            $display("too few captures reached the outputs: %0d", m_caps);
            errors++;
        end
        asserts = dcp_top_inst.seq_inst.chk_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/dcp_pkg.sv
source/dcp_sequencer.sv
source/line_buffer.sv
source/dehaze_channel.sv
source/dehaze_unit.sv
source/dcp_top.sv
verif/dcp_assertions.sv
verif/tb_dcp.sv

// ==== Makefile ====
# Verilator build and run for the dehaze display path

VERILATOR ?= verilator
TOP       ?= tb_dcp
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
